// ==== logic/mini_core_defines.svh ====
`ifndef MINI_CORE_DEFINES_SVH
`define MINI_CORE_DEFINES_SVH

// Datapath and bus address width
`define MC_XLEN     32
// Register file size, r0 reads as zero
`define MC_NREGS    8
`define MC_REG_W    3

// Instruction word layout
`define MC_OP_MSB   31
`define MC_OP_LSB   28
`define MC_RD_LSB   25
`define MC_RS1_LSB  22
`define MC_RS2_LSB  19
// Immediate sits in the low bits and is sign-extended
`define MC_IMM_W    16

`endif

// ==== logic/mini_core_pkg.sv ====
`include "mini_core_defines.svh"

package mini_core_pkg;

    // Opcode field values, 9..15 are illegal
    typedef enum logic [`MC_OP_MSB-`MC_OP_LSB:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_XOR  = 4'd3,
        OP_ADDI = 4'd4,
        OP_LW   = 4'd5,
        OP_SW   = 4'd6,
        OP_BNE  = 4'd7,
        OP_HALT = 4'd8
    } opcode_e;

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_HOLD} fetch_state_e;
    typedef enum logic [1:0] {X_IDLE, X_REQ, X_WAIT} exec_state_e;

    // ------------------------------
    // OBI master request and slave response
    typedef struct packed {
        logic                req;
        logic                we;
        logic [3:0]          be;
        logic [`MC_XLEN-1:0] addr;
        logic [`MC_XLEN-1:0] wdata;
    } obi_req_t;

    typedef struct packed {
        logic                gnt;
        logic                rvalid;
        logic [`MC_XLEN-1:0] rdata;
    } obi_rsp_t;

    // ------------------------------
    // Decode to execute
    typedef struct packed {
        logic                 valid;
        opcode_e              op;
        logic [`MC_REG_W-1:0] rd;
        logic [`MC_XLEN-1:0]  rs1_val;
        logic [`MC_XLEN-1:0]  rs2_val;
        logic [`MC_XLEN-1:0]  imm;
        logic [`MC_XLEN-1:0]  pc;
        logic                 illegal;
    } decoded_op_t;

    // Execute to write-back
    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [`MC_REG_W-1:0] rd;
        logic [`MC_XLEN-1:0]  wdata;
        logic [`MC_XLEN-1:0]  next_pc;
        logic                 halt;
        logic                 illegal;
    } exec_result_t;

endpackage

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module fetch_unit import mini_core_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                fetch_enable_i,
    input  logic [`MC_XLEN-1:0] boot_addr_i,
    input  logic                halted_i,
    input  logic                retire_i,
    input  logic [`MC_XLEN-1:0] next_pc_i,
    output logic                instr_req_o,
    output logic [`MC_XLEN-1:0] instr_addr_o,
    input  logic                instr_gnt_i,
    input  logic                instr_rvalid_i,
    input  logic [`MC_XLEN-1:0] instr_rdata_i,
    output logic                instr_valid_o,
    output logic [`MC_XLEN-1:0] instr_o,
    output logic [`MC_XLEN-1:0] pc_o
);

    fetch_state_e        state_q;
    logic [`MC_XLEN-1:0] pc_q;
    logic [`MC_XLEN-1:0] instr_q;
    logic                instr_valid_q;

    // Request and address come straight from state and PC
    assign instr_req_o   = (state_q == F_REQ);
    assign instr_addr_o  = pc_q;
    assign instr_valid_o = instr_valid_q;
    assign instr_o       = instr_q;
    assign pc_o          = pc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= F_IDLE;
            pc_q          <= boot_addr_i;
            instr_valid_q <= 1'b0;
        end else begin
            // Strobe lasts a single cycle
            instr_valid_q <= 1'b0;
            case (state_q)
                F_IDLE: begin
                    if (fetch_enable_i && !halted_i) begin
                        state_q <= F_REQ;
                    end
                end
                // Hold req and addr until the address phase
                F_REQ: begin
                    if (instr_gnt_i) begin
                        state_q <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (instr_rvalid_i) begin
                        instr_q       <= instr_rdata_i;
                        instr_valid_q <= 1'b1;
                        state_q       <= F_HOLD;
                    end
                end
                // ------------------------------
                // Wait for retire, then either fetch again or park
                F_HOLD: begin
                    if (retire_i) begin
                        pc_q    <= next_pc_i;
                        state_q <= (fetch_enable_i && !halted_i) ? F_REQ : F_IDLE;
                    end
                end
                default: state_q <= F_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module decode_unit import mini_core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 instr_valid_i,
    input  logic [`MC_XLEN-1:0]  instr_i,
    input  logic [`MC_XLEN-1:0]  pc_i,
    output logic [`MC_REG_W-1:0] rs1_addr_o,
    output logic [`MC_REG_W-1:0] rs2_addr_o,
    input  logic [`MC_XLEN-1:0]  rs1_val_i,
    input  logic [`MC_XLEN-1:0]  rs2_val_i,
    output decoded_op_t          dec_o
);

    opcode_e             op;
    logic                illegal;
    logic [`MC_XLEN-1:0] imm_ext;

    // Register file is read combinationally in the decode cycle
    assign rs1_addr_o = instr_i[`MC_RS1_LSB +: `MC_REG_W];
    assign rs2_addr_o = instr_i[`MC_RS2_LSB +: `MC_REG_W];

    // Sign-extend the low immediate field
    assign imm_ext = {{(`MC_XLEN-`MC_IMM_W){instr_i[`MC_IMM_W-1]}},
                      instr_i[`MC_IMM_W-1:0]};

    always_comb begin
        op = opcode_e'(instr_i[`MC_OP_MSB:`MC_OP_LSB]);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI,
            OP_LW, OP_SW, OP_BNE, OP_HALT: illegal = 1'b0;
            // Opcodes 9..15
            default: illegal = 1'b1;
        endcase
    end

    // ------------------------------
    // Payload stays put until the next fetched word
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= instr_valid_i;
            if (instr_valid_i) begin
                dec_o.op      <= op;
                dec_o.rd      <= instr_i[`MC_RD_LSB +: `MC_REG_W];
                dec_o.rs1_val <= rs1_val_i;
                dec_o.rs2_val <= rs2_val_i;
                dec_o.imm     <= imm_ext;
                dec_o.pc      <= pc_i;
                dec_o.illegal <= illegal;
            end
        end
    end

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module execute_unit import mini_core_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,
    input  decoded_op_t  dec_i,
    output obi_req_t     data_req_o,
    input  obi_rsp_t     data_rsp_i,
    output exec_result_t res_o
);

    exec_state_e         state_q;
    obi_req_t            req_q;
    logic [`MC_XLEN-1:0] pc_plus4;
    logic [`MC_XLEN-1:0] alu_res;
    logic [`MC_XLEN-1:0] br_pc;
    logic                alu_we;
    logic                is_mem;

    assign pc_plus4   = dec_i.pc + `MC_XLEN'd4;
    assign data_req_o = req_q;

    // ------------------------------
    // ALU and branch target
    always_comb begin
        alu_res = '0;
        alu_we  = 1'b0;
        br_pc   = pc_plus4;
        is_mem  = 1'b0;
        case (dec_i.op)
            OP_ADD:  begin alu_res = dec_i.rs1_val + dec_i.rs2_val; alu_we = 1'b1; end
            OP_SUB:  begin alu_res = dec_i.rs1_val - dec_i.rs2_val; alu_we = 1'b1; end
            OP_AND:  begin alu_res = dec_i.rs1_val & dec_i.rs2_val; alu_we = 1'b1; end
            OP_XOR:  begin alu_res = dec_i.rs1_val ^ dec_i.rs2_val; alu_we = 1'b1; end
            OP_ADDI: begin alu_res = dec_i.rs1_val + dec_i.imm; alu_we = 1'b1; end
            // Offset counts words
            OP_BNE: begin
                if (dec_i.rs1_val != dec_i.rs2_val) begin
                    br_pc = pc_plus4 + {dec_i.imm[`MC_XLEN-3:0], 2'b00};
                end
            end
            OP_LW, OP_SW: is_mem = 1'b1;
            // HALT and illegal opcodes write nothing
            default: alu_we = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= X_IDLE;
            req_q       <= '0;
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= 1'b0;
            case (state_q)
                X_IDLE: begin
                    if (dec_i.valid && is_mem) begin
                        // Full-word access at rs1 + imm
                        req_q.req   <= 1'b1;
                        req_q.we    <= (dec_i.op == OP_SW);
                        req_q.be    <= 4'hf;
                        req_q.addr  <= dec_i.rs1_val + dec_i.imm;
                        req_q.wdata <= dec_i.rs2_val;
                        state_q     <= X_REQ;
                    end else if (dec_i.valid) begin
                        res_o.valid   <= 1'b1;
                        res_o.we      <= alu_we;
                        res_o.rd      <= dec_i.rd;
                        res_o.wdata   <= alu_res;
                        res_o.next_pc <= br_pc;
                        res_o.halt    <= (dec_i.op == OP_HALT) || dec_i.illegal;
                        res_o.illegal <= dec_i.illegal;
                    end
                end
                // Drop req on the address phase edge
                X_REQ: begin
                    if (data_rsp_i.gnt) begin
                        req_q.req <= 1'b0;
                        state_q   <= X_WAIT;
                    end
                end
                // Store completes on rvalid as well, but writes no register
                X_WAIT: begin
                    if (data_rsp_i.rvalid) begin
                        res_o.valid   <= 1'b1;
                        res_o.we      <= !req_q.we;
                        res_o.rd      <= dec_i.rd;
                        res_o.wdata   <= data_rsp_i.rdata;
                        res_o.next_pc <= pc_plus4;
                        res_o.halt    <= 1'b0;
                        res_o.illegal <= 1'b0;
                        state_q       <= X_IDLE;
                    end
                end
                default: state_q <= X_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/result_unit.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module result_unit import mini_core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  exec_result_t         res_i,
    input  logic [`MC_REG_W-1:0] rs1_addr_i,
    input  logic [`MC_REG_W-1:0] rs2_addr_i,
    output logic [`MC_XLEN-1:0]  rs1_val_o,
    output logic [`MC_XLEN-1:0]  rs2_val_o,
    output logic                 retire_o,
    output logic [`MC_XLEN-1:0]  next_pc_o,
    output logic                 halted_o,
    output logic                 illegal_o
);

    logic [`MC_XLEN-1:0] regs_q [`MC_NREGS];

    // r0 is hardwired to zero on the read side
    assign rs1_val_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_val_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    // ------------------------------
    // Write-back, retire and sticky status
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // Registers start at zero after reset
            for (int i = 0; i < `MC_NREGS; i++) begin
                regs_q[i] <= '0;
            end
            retire_o  <= 1'b0;
            halted_o  <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            retire_o <= res_i.valid;
            if (res_i.valid) begin
                next_pc_o <= res_i.next_pc;
                if (res_i.we && (res_i.rd != '0)) begin
                    regs_q[res_i.rd] <= res_i.wdata;
                end
                // Halted rises together with the retire pulse
                if (res_i.halt) begin
                    halted_o <= 1'b1;
                end
                if (res_i.illegal) begin
                    illegal_o <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/mini_core.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module mini_core import mini_core_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                fetch_enable_i,
    input  logic [`MC_XLEN-1:0] boot_addr_i,
    // OBI instruction port, read only
    output logic                instr_req_o,
    output logic [`MC_XLEN-1:0] instr_addr_o,
    input  logic                instr_gnt_i,
    input  logic                instr_rvalid_i,
    input  logic [`MC_XLEN-1:0] instr_rdata_i,
    // OBI data port
    output obi_req_t            data_req_o,
    input  obi_rsp_t            data_rsp_i,
    output logic                core_sleep_o,
    output logic                illegal_o
);

    logic                 instr_valid;
    logic [`MC_XLEN-1:0]  instr;
    logic [`MC_XLEN-1:0]  pc;
    logic [`MC_REG_W-1:0] rs1_addr;
    logic [`MC_REG_W-1:0] rs2_addr;
    logic [`MC_XLEN-1:0]  rs1_val;
    logic [`MC_XLEN-1:0]  rs2_val;
    decoded_op_t          dec;
    exec_result_t         res;
    logic                 retire;
    logic [`MC_XLEN-1:0]  next_pc;
    logic                 halted;

    // Sleep is the sticky halt flag
    assign core_sleep_o = halted;

    fetch_unit fetch_unit_i (
        .clk_i, .reset_i, .fetch_enable_i, .boot_addr_i,
        .halted_i (halted), .retire_i (retire), .next_pc_i (next_pc),
        .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
        .instr_valid_o (instr_valid), .instr_o (instr), .pc_o (pc)
    );

    decode_unit decode_unit_i (
        .clk_i, .reset_i, .instr_valid_i (instr_valid), .instr_i (instr), .pc_i (pc),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
        .rs1_val_i (rs1_val), .rs2_val_i (rs2_val), .dec_o (dec)
    );

    execute_unit execute_unit_i (
        .clk_i, .reset_i, .dec_i (dec), .data_req_o, .data_rsp_i, .res_o (res)
    );

    // Register file lives with write-back
    result_unit result_unit_i (
        .clk_i, .reset_i, .res_i (res),
        .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rs1_val_o (rs1_val), .rs2_val_o (rs2_val),
        .retire_o (retire), .next_pc_o (next_pc), .halted_o (halted), .illegal_o
    );

endmodule

// ==== bench/mini_core_checker.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module mini_core_checker import mini_core_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                instr_req_i,
    input  logic [`MC_XLEN-1:0] instr_addr_i,
    input  obi_req_t            data_req_i,
    input  obi_rsp_t            data_rsp_i,
    input  logic                core_sleep_i,
    input  logic                illegal_i
);

    // Expected stores in program order as filled by the reference model
    logic [`MC_XLEN-1:0] exp_addr_q [$];
    logic [`MC_XLEN-1:0] exp_data_q [$];
    logic [`MC_XLEN-1:0] boot_addr;
    string               test_name;
    // Mode 1 covers reset and idle before the first fetch
    // Mode 2 covers the quiet time after halt
    logic [1:0]          quiet_mode = 2'd0;
    bit                  first_seen;
    int                  stores_seen;
    int                  run_errors;
    int                  tests_run = 0;
    int                  tests_failed = 0;

    task automatic start_run(input string name, input logic [`MC_XLEN-1:0] boot);
        test_name = name;
        boot_addr = boot;
        exp_addr_q.delete();
        exp_data_q.delete();
        quiet_mode  = 2'd1;
        first_seen  = 1'b0;
        stores_seen = 0;
        run_errors  = 0;
    endtask

    task automatic expect_store(input logic [`MC_XLEN-1:0] addr,
                                input logic [`MC_XLEN-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic set_quiet(input logic [1:0] mode);
        quiet_mode = mode;
    endtask

    task automatic compare(input string what, input logic [31:0] exp,
                           input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            run_errors++;
        end
    endtask

    // ------------------------------
    // Bus and status monitor
    always @(posedge clk_i) begin
        if (quiet_mode != 2'd0 && (instr_req_i || data_req_i.req)) begin
            $display("Bus request seen while the core should be idle in %s", test_name);
            run_errors++;
        end
        if (quiet_mode == 2'd1 && (core_sleep_i || illegal_i)) begin
            $display("Sleep or illegal flag set before the first fetch in %s", test_name);
            run_errors++;
        end
        // First fetch must come from the boot address
        if (!reset_i && instr_req_i && !first_seen) begin
            first_seen = 1'b1;
            compare("first fetch address", boot_addr, instr_addr_i);
        end
        // Every data access uses all four byte lanes
        if (!reset_i && data_req_i.req && data_rsp_i.gnt) begin
            compare("byte enable", 32'hf, {28'd0, data_req_i.be});
        end
        // A store counts on its address phase
        if (!reset_i && data_req_i.req && data_req_i.we && data_rsp_i.gnt) begin
            stores_seen++;
            if (exp_addr_q.size() == 0) begin
                $display("Store to %h after the last expected store in %s",
                         data_req_i.addr, test_name);
                run_errors++;
            end else begin
                compare("store address", exp_addr_q.pop_front(), data_req_i.addr);
                compare("store data", exp_data_q.pop_front(), data_req_i.wdata);
            end
        end
    end

    // Closing checks of one run and its result line
    task automatic end_run(input bit exp_illegal);
        if (exp_addr_q.size() != 0) begin
            $display("FAIL %s store count: expected %0d, actual %0d", test_name,
                     stores_seen + exp_addr_q.size(), stores_seen);
            run_errors++;
        end
        compare("core_sleep_o", 32'd1, {31'd0, core_sleep_i});
        compare("illegal_o", {31'd0, exp_illegal}, {31'd0, illegal_i});
        tests_run++;
        if (run_errors == 0) begin
            $display("Test %s passed, %0d stores", test_name, stores_seen);
        end else begin
            $display("Test %s failed, %0d errors", test_name, run_errors);
            tests_failed++;
        end
    endtask

endmodule

// ==== bench/mini_core_tb.sv ====
`timescale 1ns/1ps
`include "mini_core_defines.svh"

module mini_core_tb import mini_core_pkg::*; ();

    localparam logic [`MC_XLEN-1:0] BOOT      = 32'h0000_1000;
    localparam logic [`MC_XLEN-1:0] DATA_BASE = 32'h0000_2000;
    localparam int                  BOOT_WORD = 'h400;
    localparam int                  DATA_WORD = 'h800;
    localparam int                  TIMEOUT   = 5000;

    logic                clk;
    logic                reset;
    logic                fetch_enable;
    logic                instr_req;
    logic [`MC_XLEN-1:0] instr_addr;
    logic                instr_gnt;
    logic                instr_rvalid;
    logic [`MC_XLEN-1:0] instr_rdata;
    obi_req_t            data_req;
    obi_rsp_t            data_rsp;
    logic                core_sleep;
    logic                illegal;

    // Shared instruction and data memory of 16 KiB
    logic [`MC_XLEN-1:0] mem [4096];
    logic [`MC_XLEN-1:0] prog [48];
    logic [`MC_XLEN-1:0] init_data [256];
    int                  prog_len;
    bit                  zero_delay;
    bit                  timed_out;

    always #5 clk = ~clk;

    mini_core mini_core_i (
        .clk_i          (clk),
        .reset_i        (reset),
        .fetch_enable_i (fetch_enable),
        .boot_addr_i    (BOOT),
        .instr_req_o    (instr_req),
        .instr_addr_o   (instr_addr),
        .instr_gnt_i    (instr_gnt),
        .instr_rvalid_i (instr_rvalid),
        .instr_rdata_i  (instr_rdata),
        .data_req_o     (data_req),
        .data_rsp_i     (data_rsp),
        .core_sleep_o   (core_sleep),
        .illegal_o      (illegal)
    );

    mini_core_checker checker_i (
        .clk_i        (clk),
        .reset_i      (reset),
        .instr_req_i  (instr_req),
        .instr_addr_i (instr_addr),
        .data_req_i   (data_req),
        .data_rsp_i   (data_rsp),
        .core_sleep_i (core_sleep),
        .illegal_i    (illegal)
    );

    function automatic int grant_delay();
        return zero_delay ? 0 : int'($urandom_range(3, 0));
    endfunction

    function automatic int valid_delay();
        return zero_delay ? 1 : int'($urandom_range(3, 1));
    endfunction

    // ------------------------------
    // OBI responders serve one transaction at a time
    initial begin : instr_responder
        logic [11:0] word;
        forever begin
            @(negedge clk);
            if (instr_req && !reset) begin
                repeat (grant_delay()) @(negedge clk);
                instr_gnt = 1'b1;
                word      = instr_addr[13:2];
                @(negedge clk);
                instr_gnt = 1'b0;
                repeat (valid_delay() - 1) @(negedge clk);
                instr_rvalid = 1'b1;
                instr_rdata  = mem[word];
                @(negedge clk);
                instr_rvalid = 1'b0;
            end
        end
    end

    initial begin : data_responder
        logic [`MC_XLEN-1:0] rd_word;
        forever begin
            @(negedge clk);
            if (data_req.req && !reset) begin
                repeat (grant_delay()) @(negedge clk);
                data_rsp.gnt = 1'b1;
                // Read and write happen on the address phase
                rd_word = mem[data_req.addr[13:2]];
                if (data_req.we) begin
                    mem[data_req.addr[13:2]] = data_req.wdata;
                end
                @(negedge clk);
                data_rsp.gnt = 1'b0;
                repeat (valid_delay() - 1) @(negedge clk);
                data_rsp.rvalid = 1'b1;
                data_rsp.rdata  = rd_word;
                @(negedge clk);
                data_rsp.rvalid = 1'b0;
            end
        end
    end

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
            input logic [2:0] rs1, input logic [2:0] rs2, input logic [15:0] imm);
        return {op, rd, rs1, rs2, 3'b000, imm};
    endfunction

    // ------------------------------
    // Random program that ends in HALT or an illegal word
    // Dead stores follow the stop word
    task automatic make_program(input bit use_loads, input bit end_illegal);
        int          stop;
        int          kind;
        logic [2:0]  rd;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [15:0] addr;
        stop = int'($urandom_range(40, 20)) - 1;
        for (int i = 0; i < 256; i++) begin
            init_data[8'(i)] = $urandom();
        end
        for (int i = 0; i < stop; i++) begin
            rd   = 3'($urandom_range(7, 0));
            rs1  = 3'($urandom_range(7, 0));
            rs2  = 3'($urandom_range(7, 0));
            addr = 16'(DATA_BASE + 4 * $urandom_range(255, 0));
            kind = int'($urandom_range(use_loads ? 9 : 7, 0));
            case (kind)
                0, 1, 2, 3: prog[6'(i)] = encode(4'(kind), rd, rs1, rs2, 16'h0);
                4: prog[6'(i)] = encode(OP_ADDI, rd, rs1, 3'd0, 16'($urandom()));
                5, 7: prog[6'(i)] = encode(OP_SW, 3'd0, 3'd0, rs2, addr);
                // Target never passes the stop word
                6: prog[6'(i)] = encode(OP_BNE, 3'd0, rs1, rs2,
                                        16'($urandom_range(stop - i - 1, 0)));
                default: prog[6'(i)] = encode(OP_LW, rd, 3'd0, 3'd0, addr);
            endcase
        end
        if (end_illegal) begin
            prog[6'(stop)] = encode(4'($urandom_range(15, 9)), 3'd0, 3'd0, 3'd0, 16'h0);
        end else begin
            prog[6'(stop)] = encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0);
        end
        for (int i = stop + 1; i < stop + 5; i++) begin
            prog[6'(i)] = encode(OP_SW, 3'd0, 3'd0, 3'd1, 16'(DATA_BASE));
        end
        prog_len = stop + 5;
    endtask

    task automatic load_memory();
        // Unused words hold illegal opcode 15 tagged with their index
        for (int i = 0; i < 4096; i++) begin
            mem[12'(i)] = 32'hf000_0000 | 32'(i);
        end
        for (int i = 0; i < prog_len; i++) begin
            mem[12'(BOOT_WORD + i)] = prog[6'(i)];
        end
        for (int i = 0; i < 256; i++) begin
            mem[12'(DATA_WORD + i)] = init_data[8'(i)];
        end
    endtask

    // Reference model of the ISA that queues every store for the checker
    task automatic run_model(output bit ends_illegal);
        logic [31:0] regs [8];
        logic [31:0] dmem [256];
        logic [31:0] word;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        int          pc;
        bit          done;
        for (int i = 0; i < 8; i++) begin
            regs[3'(i)] = '0;
        end
        dmem = init_data;
        pc = 0;
        done = 1'b0;
        ends_illegal = 1'b0;
        while (!done) begin
            word = prog[6'(pc)];
            a    = regs[word[24:22]];
            b    = regs[word[21:19]];
            addr = a + {{16{word[15]}}, word[15:0]};
            pc   = pc + 1;
            case (word[31:28])
                OP_ADD:  regs[word[27:25]] = a + b;
                OP_SUB:  regs[word[27:25]] = a - b;
                OP_AND:  regs[word[27:25]] = a & b;
                OP_XOR:  regs[word[27:25]] = a ^ b;
                OP_ADDI: regs[word[27:25]] = addr;
                OP_LW:   regs[word[27:25]] = dmem[addr[9:2]];
                OP_SW: begin
                    dmem[addr[9:2]] = b;
                    checker_i.expect_store(addr, b);
                end
                OP_BNE: begin
                    if (a != b) begin
                        pc = pc + int'($signed(word[15:0]));
                    end
                end
                OP_HALT: done = 1'b1;
                default: begin
                    done = 1'b1;
                    ends_illegal = 1'b1;
                end
            endcase
            regs[0] = '0;
        end
    endtask

    // ------------------------------
    // One run goes through reset, idle with enable low, run to sleep and a quiet phase
    task automatic run_test(input string name, input bit no_delay, input int idle_cycles);
        bit ends_illegal;
        int waited;
        if (!timed_out) begin
            zero_delay   = no_delay;
            fetch_enable = 1'b0;
            reset        = 1'b1;
            @(negedge clk);
            checker_i.start_run(name, BOOT);
            load_memory();
            run_model(ends_illegal);
            repeat (15) @(negedge clk);
            reset = 1'b0;
            repeat (idle_cycles) @(negedge clk);
            checker_i.set_quiet(2'd0);
            fetch_enable = 1'b1;
            waited = 0;
            while (!core_sleep && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!core_sleep) begin
                $display("Timeout in %s: core did not go to sleep within %0d cycles",
                         name, TIMEOUT);
                timed_out = 1'b1;
            end else begin
                checker_i.set_quiet(2'd2);
                repeat (50) @(negedge clk);
                checker_i.set_quiet(2'd0);
                checker_i.end_run(ends_illegal);
            end
            fetch_enable = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'hde4b_1473));
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_enable = 1'b0;
        instr_gnt    = 1'b0;
        instr_rvalid = 1'b0;
        instr_rdata  = '0;
        data_rsp     = '0;
        timed_out    = 1'b0;
        make_program(1'b0, 1'b0);
        run_test("reset_enable", 1'b0, 30);
        for (int t = 0; t < 4; t++) begin
            make_program(1'b0, 1'b0);
            run_test($sformatf("alu_branch_%0d", t), 1'b0, 2);
        end
        for (int t = 0; t < 4; t++) begin
            make_program(1'b1, 1'b0);
            run_test($sformatf("loads_%0d", t), 1'b0, 2);
        end
        // Same program without and with bus stalls
        make_program(1'b1, 1'b0);
        run_test("backpressure_zero", 1'b1, 2);
        run_test("backpressure_random", 1'b0, 2);
        make_program(1'b0, 1'b0);
        run_test("halt", 1'b0, 2);
        for (int t = 0; t < 3; t++) begin
            make_program(1'b1, 1'b1);
            run_test($sformatf("illegal_%0d", t), 1'b0, 2);
        end
        $display("Tests run: %0d, failed: %0d", checker_i.tests_run + int'(timed_out),
                 checker_i.tests_failed + int'(timed_out));
        if (timed_out || checker_i.tests_failed != 0) begin
            $display("Test failures found");
        end else begin
            $display("All tests passed!");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/mini_core_pkg.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/mini_core.sv
bench/mini_core_checker.sv
bench/mini_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the mini_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f vlog.f --top-module mini_core_tb -o mini_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/mini_core_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
